// File: Makefile
# Verilator build and run of the eforth engine testbench

VERILATOR ?= verilator
TOP       ?= tb_eforth
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(filter-out +%,$(shell cat $(FLIST))) $(wildcard hdl/*.svh testbench/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)

check: run
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "eforth testbench failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Result: PASSED" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
+incdir+hdl
+incdir+testbench
hdl/eforth_pkg.sv
hdl/stack_lifo.sv
hdl/code_mem.sv
hdl/inner_interp.sv
hdl/eforth_core.sv
testbench/tb_eforth.sv

// File: hdl/code_mem.sv
// byte wide code memory
// host write port, one cycle read port for the interpreter
`default_nettype none

module code_mem #(
    parameter int SIZE = 4096               // bytes
) (
    input  wire                    clk,
    input  wire eforth_pkg::load_t load,    // already gated by run state
    input  wire eforth_pkg::addr_t rd_addr,
    output logic [7:0]             rd_data
);
    logic [7:0] mem [SIZE];

    // host side
    always_ff @(posedge clk) begin
        if (load.we) begin
            mem[load.addr] <= load.data;
        end
    end

    // registered read, data one cycle after address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: hdl/eforth_core.sv
// eforth engine top
// code memory, data and return stacks around the inner interpreter
`default_nettype none

`include "eforth_defs.svh"

module eforth_core (
    input  wire                       clk,
    input  wire                       rst,
    input  wire eforth_pkg::load_t    load,
    input  wire eforth_pkg::run_req_t run_req,
    output eforth_pkg::run_rsp_t      run_rsp
);
    import eforth_pkg::*;

    load_t                mem_load;
    addr_t                mem_addr;
    logic [7:0]           mem_data;
    logic                 busy;

    logic                 ds_push, ds_pop, ds_full, ds_empty;
    cell_t                ds_din, ds_top;
    logic [`EF_DS_DW-1:0] ds_depth;

    logic                 rs_push, rs_pop, rs_full, rs_empty;
    addr_t                rs_din, rs_top;
    logic [`EF_RS_DW-1:0] rs_depth;

    // host writes only land while idle
    always_comb begin
        mem_load    = load;
        mem_load.we = load.we & ~busy;
    end

    code_mem #(.SIZE(`EF_MEM_SIZE)) u_mem (
        .clk     (clk),
        .load    (mem_load),
        .rd_addr (mem_addr),
        .rd_data (mem_data)
    );

    stack_lifo #(.DEPTH(`EF_DS_DEPTH), .entry_t(cell_t)) u_ds (
        .clk   (clk),
        .rst   (rst),
        .push  (ds_push),
        .pop   (ds_pop),
        .din   (ds_din),
        .top   (ds_top),        // second item, tos sits in the interpreter
        .depth (ds_depth),
        .full  (ds_full),
        .empty (ds_empty)
    );

    stack_lifo #(.DEPTH(`EF_RS_DEPTH), .entry_t(addr_t)) u_rs (
        .clk   (clk),
        .rst   (rst),
        .push  (rs_push),
        .pop   (rs_pop),
        .din   (rs_din),
        .top   (rs_top),
        .depth (rs_depth),
        .full  (rs_full),
        .empty (rs_empty)
    );

    inner_interp u_interp (
        .clk      (clk),
        .rst      (rst),
        .run_req  (run_req),
        .run_rsp  (run_rsp),
        .busy     (busy),
        .mem_addr (mem_addr),
        .mem_data (mem_data),
        .ds_push  (ds_push),
        .ds_pop   (ds_pop),
        .ds_din   (ds_din),
        .ds_top   (ds_top),
        .ds_depth (ds_depth),
        .ds_full  (ds_full),
        .ds_empty (ds_empty),
        .rs_push  (rs_push),
        .rs_pop   (rs_pop),
        .rs_din   (rs_din),
        .rs_top   (rs_top),
        .rs_depth (rs_depth),
        .rs_full  (rs_full),
        .rs_empty (rs_empty)
    );

endmodule

`default_nettype wire

// File: hdl/eforth_defs.svh
// eforth engine sizing
// cell, code address and stack geometry shared by rtl and testbench
`ifndef EFORTH_DEFS_SVH
`define EFORTH_DEFS_SVH

// data path
`define EF_CELL_W    32
`define EF_ADDR_W    12                      // 4K byte code space

// stack depths, tos register not counted
`define EF_DS_DEPTH  16
`define EF_RS_DEPTH  16

// depth port widths of the stacks
`define EF_DS_DW     $clog2(`EF_DS_DEPTH + 1)
`define EF_RS_DW     $clog2(`EF_RS_DEPTH + 1)

// code memory bytes at the top level
`define EF_MEM_SIZE  4096

`endif

// File: hdl/eforth_pkg.sv
// eforth engine types
// opcodes, fault codes and the host side structs
`default_nettype none

`include "eforth_defs.svh"

package eforth_pkg;

    typedef logic [`EF_CELL_W-1:0] cell_t;   // one data cell
    typedef logic [`EF_ADDR_W-1:0] addr_t;   // code byte address

    // byte codes, contiguous so anything above op_zeq is illegal
    typedef enum logic [7:0] {
        op_nop   = 8'h00,
        op_dolit = 8'h01,    // 4 operand bytes, little endian
        op_bran  = 8'h02,    // 2 byte target
        op_zbran = 8'h03,    // 2 byte target, taken on zero
        op_call  = 8'h04,    // 2 byte target
        op_exit  = 8'h05,
        op_bye   = 8'h06,
        op_dup   = 8'h07,
        op_drop  = 8'h08,
        op_over  = 8'h09,
        op_swap  = 8'h0a,
        op_tor   = 8'h0b,
        op_rfrom = 8'h0c,
        op_add   = 8'h0d,
        op_sub   = 8'h0e,
        op_and   = 8'h0f,
        op_or    = 8'h10,
        op_xor   = 8'h11,
        op_neg   = 8'h12,
        op_zeq   = 8'h13
    } opcode_e;

    typedef enum logic [1:0] {
        fault_none      = 2'd0,
        fault_illegal   = 2'd1,
        fault_overflow  = 2'd2,
        fault_underflow = 2'd3
    } fault_e;

    typedef struct packed {
        logic  req;          // four phase start
        addr_t pfa;          // first opcode
    } run_req_t;

    typedef struct packed {
        logic       ack;
        cell_t      tos;     // final top of stack, 0 when empty
        logic [4:0] depth;   // data items incl tos
        fault_e     fault;
    } run_rsp_t;

    typedef struct packed {
        logic       we;
        addr_t      addr;
        logic [7:0] data;
    } load_t;

endpackage

`default_nettype wire

// File: hdl/inner_interp.sv
// eforth inner interpreter
// byte fetch, operand assembly and primitive execute with tos in a register
`default_nettype none

`include "eforth_defs.svh"

module inner_interp (
    input  wire                          clk,
    input  wire                          rst,
    input  wire eforth_pkg::run_req_t    run_req,
    output eforth_pkg::run_rsp_t         run_rsp,
    output logic                         busy,
    output eforth_pkg::addr_t            mem_addr,
    input  wire [7:0]                    mem_data,
    output logic                         ds_push,
    output logic                         ds_pop,
    output eforth_pkg::cell_t            ds_din,
    input  wire eforth_pkg::cell_t       ds_top,
    input  wire [`EF_DS_DW-1:0]          ds_depth,
    input  wire                          ds_full,
    input  wire                          ds_empty,
    output logic                         rs_push,
    output logic                         rs_pop,
    output eforth_pkg::addr_t            rs_din,
    input  wire eforth_pkg::addr_t       rs_top,
    input  wire [`EF_RS_DW-1:0]          rs_depth,
    input  wire                          rs_full,
    input  wire                          rs_empty
);
    import eforth_pkg::*;

    typedef enum logic [2:0] {
        st_idle, st_fetch, st_decode, st_operand, st_execute, st_done
    } state_e;

    state_e     state;
    addr_t      ip;
    cell_t      tos;
    logic       tos_valid;      // tos holds a live item
    opcode_e    op;
    cell_t      lit;            // operand bytes land here
    logic [1:0] bidx;           // operand byte index
    logic       phase;          // 0 address out, 1 byte in
    logic       ack_q;
    cell_t      res_tos;
    logic [4:0] res_depth;
    fault_e     res_fault;

    opcode_e    dec_op;
    logic       dec_legal;
    logic       dec_opnd;       // decoded op carries operands
    addr_t      target;
    logic [4:0] items;          // logical data stack depth

    // execute step results
    cell_t      tos_nxt;
    logic       tv_nxt;
    addr_t      ip_nxt;
    fault_e     flt;
    logic       stop;
    logic       pop_tos;        // refill tos from the data stack
    logic [1:0] need;           // items the op consumes

    assign dec_op    = opcode_e'(mem_data);
    assign dec_legal = (mem_data <= op_zeq);
    assign dec_opnd  = (dec_op inside {op_dolit, op_bran, op_zbran, op_call});
    assign target    = lit[`EF_ADDR_W-1:0];
    assign items     = 5'(ds_depth) + 5'(tos_valid);
    assign mem_addr  = ip;
    assign ds_din    = tos;     // only tos ever spills
    assign busy      = (state != st_idle) || run_req.req;
    assign run_rsp   = '{ack: ack_q, tos: res_tos, depth: res_depth, fault: res_fault};

    always_comb begin
        ds_push = 1'b0;
        ds_pop  = 1'b0;
        rs_push = 1'b0;
        rs_pop  = 1'b0;
        rs_din  = ip;           // return address for call
        tos_nxt = tos;
        tv_nxt  = tos_valid;
        ip_nxt  = ip;
        flt     = fault_none;
        stop    = 1'b0;
        pop_tos = 1'b0;
        need    = 2'd0;
        if (state == st_done) begin
            ds_pop = !ds_empty; // drain both stacks for the next run
            rs_pop = !rs_empty;
        end else if (state == st_execute) begin
            case (op)
                op_nop: ;
                op_dolit: begin
                    ds_push = tos_valid;    // spill old tos
                    tos_nxt = lit;
                    tv_nxt  = 1'b1;
                end
                op_bran:  ip_nxt = target;
                op_zbran: begin
                    need    = 2'd1;
                    pop_tos = 1'b1;
                    if (tos == '0) ip_nxt = target;
                end
                op_call: begin
                    rs_push = 1'b1;
                    ip_nxt  = target;
                end
                op_exit: begin
                    rs_pop = 1'b1;
                    ip_nxt = rs_top;
                end
                op_bye: stop = 1'b1;
                op_dup: begin
                    need    = 2'd1;
                    ds_push = 1'b1;
                end
                op_drop: begin
                    need    = 2'd1;
                    pop_tos = 1'b1;
                end
                op_over: begin
                    need    = 2'd2;
                    ds_push = 1'b1;
                    tos_nxt = ds_top;
                end
                op_swap: begin
                    need    = 2'd2;
                    ds_push = 1'b1;     // with pop, rewrites second item
                    ds_pop  = 1'b1;
                    tos_nxt = ds_top;
                end
                op_tor: begin
                    need    = 2'd1;
                    rs_push = 1'b1;
                    rs_din  = tos[`EF_ADDR_W-1:0];  // rs is address wide
                    pop_tos = 1'b1;
                end
                op_rfrom: begin
                    rs_pop  = 1'b1;
                    ds_push = tos_valid;
                    tos_nxt = cell_t'(rs_top);
                    tv_nxt  = 1'b1;
                end
                op_add: begin need = 2'd2; ds_pop = 1'b1; tos_nxt = tos + ds_top; end
                op_sub: begin need = 2'd2; ds_pop = 1'b1; tos_nxt = tos - ds_top; end
                op_and: begin need = 2'd2; ds_pop = 1'b1; tos_nxt = tos & ds_top; end
                op_or:  begin need = 2'd2; ds_pop = 1'b1; tos_nxt = tos | ds_top; end
                op_xor: begin need = 2'd2; ds_pop = 1'b1; tos_nxt = tos ^ ds_top; end
                op_neg: begin
                    need    = 2'd1;
                    tos_nxt = '0 - tos;
                end
                op_zeq: begin
                    need    = 2'd1;
                    tos_nxt = {`EF_CELL_W{tos == '0}};  // true is all ones
                end
                default: stop = 1'b1;   // decode already filters these
            endcase
            if (pop_tos) begin
                ds_pop  = !ds_empty;
                tos_nxt = ds_empty ? '0 : ds_top;
                tv_nxt  = !ds_empty;
            end
            // stack bounds
            if (items < 5'(need) || (rs_pop && rs_empty)) begin
                flt = fault_underflow;
            end else if ((ds_push && !ds_pop && ds_full) || (rs_push && rs_full)) begin
                flt = fault_overflow;
            end
            if (flt != fault_none) begin
                ds_push = 1'b0;         // faulting op leaves stacks alone
                ds_pop  = 1'b0;
                rs_push = 1'b0;
                rs_pop  = 1'b0;
                stop    = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            ack_q     <= 1'b0;
            tos_valid <= 1'b0;
            phase     <= 1'b0;
            bidx      <= 2'd0;
        end else begin
            case (state)
                st_idle: if (run_req.req) begin
                    ip        <= run_req.pfa;
                    tos       <= '0;
                    tos_valid <= 1'b0;
                    state     <= st_fetch;
                end
                st_fetch: begin
                    ip    <= ip + 1'b1;     // byte comes back in decode
                    state <= st_decode;
                end
                st_decode: begin
                    op    <= dec_op;
                    bidx  <= 2'd0;
                    phase <= 1'b0;
                    if (!dec_legal) begin
                        res_tos   <= tos;
                        res_depth <= items;
                        res_fault <= fault_illegal;
                        ack_q     <= 1'b1;
                        state     <= st_done;
                    end else if (dec_opnd) begin
                        state <= st_operand;
                    end else begin
                        state <= st_execute;
                    end
                end
                st_operand: begin
                    if (!phase) begin
                        ip    <= ip + 1'b1;
                        phase <= 1'b1;
                    end else begin
                        lit[8*bidx +: 8] <= mem_data;   // little endian
                        phase <= 1'b0;
                        bidx  <= bidx + 1'b1;
                        if (bidx == ((op == op_dolit) ? 2'd3 : 2'd1)) state <= st_execute;
                    end
                end
                st_execute: begin
                    ip        <= ip_nxt;
                    tos       <= tos_nxt;
                    tos_valid <= tv_nxt;
                    if (stop) begin
                        res_tos   <= tos;           // state before the op
                        res_depth <= items;
                        res_fault <= flt;
                        ack_q     <= 1'b1;
                        state     <= st_done;
                    end else begin
                        state <= st_fetch;
                    end
                end
                st_done: begin
                    // ack held until req drops and the stacks are drained
                    if (!run_req.req && ds_empty && rs_empty) begin
                        ack_q <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/stack_lifo.sv
// generic LIFO on a register array with a fill pointer
// push and pop in one cycle overwrite the top entry
`default_nettype none

module stack_lifo #(
    parameter int  DEPTH   = 16,            // power of two
    parameter type entry_t = logic [31:0]
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         push,
    input  wire                         pop,
    input  wire entry_t                 din,
    output entry_t                      top,
    output logic [$clog2(DEPTH+1)-1:0]  depth,
    output logic                        full,
    output logic                        empty
);
    localparam int IW = $clog2(DEPTH);      // slot index width
    localparam int PW = $clog2(DEPTH + 1);  // count width

    entry_t        mem [DEPTH];
    logic [PW-1:0] ptr;                     // entries held
    logic [IW-1:0] top_idx;
    logic [IW-1:0] wr_idx;

    // wraps when empty, caller never reads top then
    assign top_idx = IW'(ptr - 1'b1);
    assign wr_idx  = IW'(ptr);

    assign top   = mem[top_idx];
    assign depth = ptr;
    assign full  = (ptr == PW'(DEPTH));
    assign empty = (ptr == '0);

    // pointer, no bounds guard here
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (push && !pop) begin
            ptr <= ptr + 1'b1;
        end else if (pop && !push) begin
            ptr <= ptr - 1'b1;
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push && pop) begin
            mem[top_idx] <= din;            // replace top in place
        end else if (push) begin
            mem[wr_idx] <= din;             // next free slot
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_forth_model.svh
// reference eforth interpreter for the testbench
// runs a byte image from a pfa and predicts tos, depth and fault
`ifndef TB_FORTH_MODEL_SVH
`define TB_FORTH_MODEL_SVH

typedef logic [7:0] image_t [IMG_SIZE];

// returns 0 when the program leaves the image or runs past the step bound
function automatic bit predict_run(input image_t img, input int pfa, output cell_t m_tos,
                                   output logic [4:0] m_depth, output fault_e m_fault);
    cell_t       st [17];       // whole data stack, tos at st[n-1]
    logic [11:0] rs [16];       // return stack is address wide
    cell_t       lit;
    cell_t       tmp;
    logic [7:0]  op;
    int          n;
    int          rn;
    int          ip;
    int          need;
    int          step;
    n       = 0;
    rn      = 0;
    ip      = pfa;
    m_fault = fault_none;
    for (step = 0; step < 2000; step++) begin
        if (ip < 0 || ip + 5 > IMG_SIZE) return 1'b0;  // wandered off the image
        op      = img[ip];
        lit     = {img[ip+4], img[ip+3], img[ip+2], img[ip+1]};
        m_tos   = (n > 0) ? st[n-1] : '0;   // result shows the state before the last op
        m_depth = 5'(n);
        ip      = ip + 1;
        need    = 0;
        if (op inside {op_zbran, op_dup, op_drop, op_tor, op_neg, op_zeq}) need = 1;
        if (op inside {op_over, op_swap, op_add, op_sub, op_and, op_or, op_xor}) need = 2;
        if (op > op_zeq) begin
            m_fault = fault_illegal;
        end else if (n < need || (rn == 0 && op inside {op_exit, op_rfrom})) begin
            m_fault = fault_underflow;
        end else if ((n == 17 && op inside {op_dolit, op_dup, op_over, op_rfrom}) ||
                     (rn == 16 && op inside {op_call, op_tor})) begin
            m_fault = fault_overflow;         // 16 entries plus tos
        end
        if (m_fault != fault_none || op == op_bye) return 1'b1;
        case (op)
            op_dolit: begin
                st[n] = lit;
                n     = n + 1;
                ip    = ip + 4;
            end
            op_bran:  ip = int'(lit[11:0]);
            op_zbran: begin
                n  = n - 1;                     // flag consumed either way
                ip = (st[n] == '0) ? int'(lit[11:0]) : ip + 2;
            end
            op_call: begin
                rs[rn] = 12'(ip + 2);           // byte after the target field
                rn     = rn + 1;
                ip     = int'(lit[11:0]);
            end
            op_exit: begin
                rn = rn - 1;
                ip = int'(rs[rn]);
            end
            op_dup: begin
                st[n] = st[n-1];
                n     = n + 1;
            end
            op_drop: n = n - 1;
            op_over: begin
                st[n] = st[n-2];
                n     = n + 1;
            end
            op_swap: begin
                tmp     = st[n-1];
                st[n-1] = st[n-2];
                st[n-2] = tmp;
            end
            op_tor: begin
                rs[rn] = st[n-1][11:0];         // upper bits lost on the way
                rn     = rn + 1;
                n      = n - 1;
            end
            op_rfrom: begin
                st[n] = cell_t'(rs[rn-1]);
                rn    = rn - 1;
                n     = n + 1;
            end
            op_add: st[n-2] = st[n-1] + st[n-2];
            op_sub: st[n-2] = st[n-1] - st[n-2];   // tos minus second
            op_and: st[n-2] = st[n-1] & st[n-2];
            op_or:  st[n-2] = st[n-1] | st[n-2];
            op_xor: st[n-2] = st[n-1] ^ st[n-2];
            op_neg: st[n-1] = '0 - st[n-1];
            op_zeq: st[n-1] = (st[n-1] == '0) ? '1 : '0;
            default: ;
        endcase
        if (op inside {op_add, op_sub, op_and, op_or, op_xor}) n = n - 1;
    end
    return 1'b0;                                // step bound hit
endfunction

`endif

// File: testbench/tb_eforth.sv
// testbench for the eforth engine
// random programs loaded and run through the handshake and checked against a reference model
`default_nettype none

module tb_eforth;
    timeunit 1ns;
    timeprecision 100ps;

    import eforth_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int N_PROG     = 120;
    localparam int IMG_SIZE   = 176;            // bytes loaded per program
    localparam int SUB_ADDR   = 160;            // subroutine home
    localparam int BODY_LEN   = 40;             // main body bytes before the tail
    localparam int RUN_LIMIT  = 2000;           // cycles to wait on ack
    // at most two runs per program and each well under 10 cycles per image byte
    localparam int WATCHDOG   = 2 * N_PROG * IMG_SIZE * 10 * CLK_PERIOD;

    `include "tb_forth_model.svh"

    logic     clk = 1'b0;
    logic     rst = 1'b1;
    load_t    load;
    run_req_t run_req;
    run_rsp_t run_rsp;

    int       seed   = 64;
    int       errors = 0;
    int       checks = 0;
    image_t   img;
    int       pc;                               // generator write pointer
    int       depth_est;                        // data depth the generator tracks

    eforth_core UUT (
        .clk     (clk),
        .rst     (rst),
        .load    (load),
        .run_req (run_req),
        .run_rsp (run_rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG);
        $display("watchdog expired after %0d ns, the engine hung", WATCHDOG);
        $display("Result: FAILED");
        $finish;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic cell_t rand_cell();
        return (rand_below(4) == 0) ? '0 : cell_t'($random(seed));  // zeros for 0bran
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;                                     // drive and sample off the edge
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic put_byte(input logic [7:0] b);
        img[pc] = b;
        pc++;
    endtask

    task automatic put_lit(input cell_t v);
        put_byte(op_dolit);
        put_byte(v[7:0]);                       // little endian
        put_byte(v[15:8]);
        put_byte(v[23:16]);
        put_byte(v[31:24]);
        depth_est++;
    endtask

    task automatic put_branch(input logic [7:0] op, input int tgt);
        put_byte(op);
        put_byte(8'(tgt));
        put_byte(8'(tgt >> 8));
    endtask

    // kind 0 valid, 1 underflow, 2 overflow, 3 illegal byte
    task automatic build_program(input int kind, output int pfa);
        int i;
        int r;
        int k;
        for (i = 0; i < IMG_SIZE; i++) img[i] = 8'($random(seed));
        pc = SUB_ADDR;                          // depth neutral subroutine
        put_lit(rand_cell());
        put_byte((rand_below(2) == 1) ? op_xor : op_sub);
        if (rand_below(2) == 1) put_byte(op_zeq);
        put_byte(op_exit);
        pfa       = rand_below(16);
        pc        = pfa;
        depth_est = 0;
        while (pc < pfa + BODY_LEN) begin
            r = rand_below(10);
            if (depth_est < 2 || (r == 0 && depth_est < 12)) begin
                put_lit(rand_cell());
            end else if (r < 3) begin
                put_byte(8'(op_add + rand_below(5)));   // add sub and or xor
                depth_est--;
            end else if (r == 3) begin
                put_byte(8'(op_neg + rand_below(2)));
            end else if (r == 4) begin
                k = (depth_est >= 12) ? 1 : rand_below(4);
                put_byte(8'(op_dup + k));               // dup drop over swap
                if (k == 0 || k == 2) depth_est++;
                if (k == 1) depth_est--;
            end else if (r == 5) begin
                put_byte(op_tor);                       // park tos on the return stack
                put_byte(op_neg);
                put_byte(op_rfrom);
            end else if (r == 6) begin
                if (rand_below(2) == 1) put_byte(op_zeq);
                k = 1 + rand_below(4);
                put_branch(op_zbran, pc + 3 + k);
                depth_est--;
                repeat (k) put_byte((rand_below(2) == 1) ? op_neg : op_nop);
            end else if (r == 7) begin
                k = 1 + rand_below(4);
                put_branch(op_bran, pc + 3 + k);
                repeat (k) put_byte(8'($random(seed)));  // skipped garbage
            end else if (r == 8) begin
                put_branch(op_call, SUB_ADDR);
            end else begin
                put_byte(op_nop);
            end
        end
        case (kind)
            1: repeat (depth_est + 1) put_byte(op_drop);     // last drop hits empty
            2: repeat (18) put_lit(rand_cell());
            3: put_byte(8'(8'h14 + rand_below(236)));        // past the last opcode
            default: begin
                while (depth_est > 1) begin                  // fold the stack into tos
                    put_byte(op_xor);
                    depth_est--;
                end
            end
        endcase
        put_byte(op_bye);
    endtask

    task automatic load_image();
        int i;
        for (i = 0; i < IMG_SIZE; i++) begin
            load = '{we: 1'b1, addr: addr_t'(i), data: img[i]};
            next_cycle();
        end
        load.we = 1'b0;
    endtask

    task automatic check_result(input run_rsp_t rsp, input cell_t tos, input logic [4:0] depth,
                                input fault_e fault);
        compare("run_rsp.tos", rsp.tos, tos);
        compare("run_rsp.depth", 32'(rsp.depth), 32'(depth));
        compare("run_rsp.fault", 32'(rsp.fault), 32'(fault));
    endtask

    // four phase run that optionally hammers loads while req is high
    task automatic run_handshake(input int pfa, input bit tamper, input cell_t exp_tos,
                                 input logic [4:0] exp_depth, input fault_e exp_fault);
        int cnt;
        compare("run_rsp.ack", 32'(run_rsp.ack), 32'h0);    // low before req
        run_req = '{req: 1'b1, pfa: addr_t'(pfa)};
        cnt     = 0;
        next_cycle();
        while (!run_rsp.ack && cnt < RUN_LIMIT) begin
            if (tamper) load = '{we: 1'b1, addr: addr_t'(pfa + rand_below(8)), data: 8'hff};
            next_cycle();
            cnt++;
        end
        load.we = 1'b0;
        if (!run_rsp.ack) begin
            errors++;
            $display("no ack within %0d cycles for the program at pfa %0h", RUN_LIMIT, pfa);
        end
        check_result(run_rsp, exp_tos, exp_depth, exp_fault);
        repeat (1 + rand_below(15)) begin
            next_cycle();
            compare("run_rsp.ack", 32'(run_rsp.ack), 32'h1);  // held while req high
        end
        check_result(run_rsp, exp_tos, exp_depth, exp_fault);  // result still stable
        run_req.req = 1'b0;
        cnt         = 0;
        next_cycle();
        while (run_rsp.ack && cnt < RUN_LIMIT) begin
            next_cycle();
            cnt++;
        end
        if (run_rsp.ack) begin
            errors++;
            $display("ack stayed high after req fell at pfa %0h", pfa);
        end
    endtask

    initial begin
        cell_t      m_tos;
        logic [4:0] m_depth;
        fault_e     m_fault;
        int         pfa;
        int         kind;
        int         p;
        load    = '0;
        run_req = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        next_cycle();
        for (p = 0; p < N_PROG; p++) begin
            kind = (p % 4 == 3) ? 1 + rand_below(3) : 0;  // every fourth one faults
            build_program(kind, pfa);
            if (!predict_run(img, pfa, m_tos, m_depth, m_fault)) begin
                errors++;
                $display("program %0d did not terminate in the reference model", p);
            end else begin
                load_image();
                run_handshake(pfa, p % 5 == 1, m_tos, m_depth, m_fault);
                if (p % 5 == 1) begin
                    run_handshake(pfa, 1'b0, m_tos, m_depth, m_fault);  // image must be untouched
                end
            end
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
